//--- vdiv_unit.f
rtl/vdiv_pkg.sv
rtl/int_divider.sv
rtl/fp_div.sv
rtl/vdiv_collector.sv
rtl/vdiv_unit.sv
sim/vdiv_assertions.sv
sim/vdiv_tb.sv

//--- sim/vdiv_tb.sv
// Vector divide testbench
`timescale 1ns/10ps

module vdiv_tb;
    import vdiv_pkg::*;

    localparam int N_RANDOM       = 24;
    localparam int N_SPECIAL      = 4;
    localparam int N_MIXED        = 12;
    localparam int N_RANGE        = 4;
    localparam int N_BUSY         = 3;
    localparam int NUM_VECTORS    = N_RANDOM + N_SPECIAL + N_MIXED + N_RANGE + N_BUSY;
    localparam int TIMEOUT_CYCLES = 20 * NUM_VECTORS + 100;
    // Start to done, one cycle per lane on the special path plus the collector
    localparam int LAT_SPECIAL    = 2;
    localparam int LAT_ORDINARY   = DIV_CYCLES + 2;
    localparam int EXP_MAX        = (1 << EXP_WIDTH) - 1;
    localparam int EXP_MASK       = (1 << (EXP_WIDTH + 1)) - 1;
    localparam int MANT_MASK      = (1 << MANT_WIDTH) - 1;
    // Exponents 96 to 159 keep random quotients inside the normal range
    localparam int NORM_EXP_LO    = 96;
    localparam int NORM_EXP_BITS  = 6;
    localparam logic [31:0] LFSR_SEED = 32'he459_193f;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                 CLK;
    logic                 nRST;
    logic                 start;
    logic [VEC_WIDTH-1:0] a_vec;
    logic [VEC_WIDTH-1:0] b_vec;
    logic                 busy;
    logic                 done;
    logic [VEC_WIDTH-1:0] result_vec;

    logic [31:0] lfsr_state  = LFSR_SEED;
    int          cycle_count = 0;
    int          accepted    = 0;
    int          done_count  = 0;
    int          check_count = 0;
    int          error_count = 0;

    // One entry per accepted start, oldest first
    logic [VEC_WIDTH-1:0] expect_q[$];
    int                   start_q[$];
    int                   latency_q[$];
    string                name_q[$];

    vdiv_unit i_vdiv_unit (
        .CLK       (CLK),
        .nRST      (nRST),
        .start     (start),
        .a_vec     (a_vec),
        .b_vec     (b_vec),
        .busy      (busy),
        .done      (done),
        .result_vec(result_vec)
    );

    bind vdiv_unit vdiv_assertions i_vdiv_assertions (
        .CLK  (CLK),
        .nRST (nRST),
        .start(start),
        .busy (busy),
        .done (done)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {1'b0, state[31:1]} ^ (state[0] ? LFSR_TAPS : 32'h0);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    function automatic logic [FP_WIDTH-1:0] make_normal(input int exp_lo, input int exp_bits);
        logic                  sign;
        logic [EXP_WIDTH-1:0]  exponent;
        logic [MANT_WIDTH-1:0] mant;
        sign     = 1'(take_bits(1));
        exponent = EXP_WIDTH'(exp_lo + int'(take_bits(exp_bits)));
        mant     = MANT_WIDTH'(take_bits(MANT_WIDTH));
        return {sign, exponent, mant};
    endfunction

    // Kinds 0 zero, 1 subnormal, 2 infinity, 3 NaN
    function automatic logic [FP_WIDTH-1:0] make_special(input int kind);
        logic [FP_WIDTH-1:0] value;
        value = make_normal(1, 7);
        case (kind)
            0: value[FP_WIDTH-2:0] = '0;
            1: value[FP_WIDTH-2 -: EXP_WIDTH] = '0;
            2: begin
                value[FP_WIDTH-2 -: EXP_WIDTH] = '1;
                value[MANT_WIDTH-1:0] = '0;
            end
            default: begin
                value[FP_WIDTH-2 -: EXP_WIDTH] = '1;
                value[0] = 1'b1;
            end
        endcase
        return value;
    endfunction

    // Exponent pairs around the overflow and underflow edges
    function automatic logic [2*EXP_WIDTH-1:0] range_pair(input int idx);
        case (idx)
            0:  return {8'd254, 8'd1};
            1:  return {8'd200, 8'd70};
            2:  return {8'd128, 8'd1};
            3:  return {8'd129, 8'd1};
            4:  return {8'd191, 8'd64};
            5:  return {8'd130, 8'd2};
            6:  return {8'd160, 8'd33};
            7:  return {8'd250, 8'd120};
            8:  return {8'd1, 8'd254};
            9:  return {8'd1, 8'd128};
            10: return {8'd1, 8'd127};
            11: return {8'd2, 8'd128};
            12: return {8'd10, 8'd137};
            13: return {8'd64, 8'd190};
            14: return {8'd127, 8'd254};
            default: return {8'd100, 8'd226};
        endcase
    endfunction

    function automatic logic special_pair(input logic [FP_WIDTH-1:0] a,
                                          input logic [FP_WIDTH-1:0] b);
        int ea;
        int eb;
        ea = a[FP_WIDTH-2 -: EXP_WIDTH];
        eb = b[FP_WIDTH-2 -: EXP_WIDTH];
        return (ea == 0) || (ea == EXP_MAX) || (eb == 0) || (eb == EXP_MAX);
    endfunction

    // Expected lane result from the format rules
    function automatic logic [FP_WIDTH-1:0] ref_divide(input logic [FP_WIDTH-1:0] a,
                                                       input logic [FP_WIDTH-1:0] b);
        logic sign;
        int   ea;
        int   eb;
        int   ma;
        int   mb;
        int   quo;
        int   exp_q;
        int   mant;
        logic nan_in;
        logic inf_in;
        logic zero_in;
        sign = a[FP_WIDTH-1] ^ b[FP_WIDTH-1];
        ea   = a[FP_WIDTH-2 -: EXP_WIDTH];
        eb   = b[FP_WIDTH-2 -: EXP_WIDTH];
        ma   = a[MANT_WIDTH-1:0];
        mb   = b[MANT_WIDTH-1:0];
        nan_in = (ea == EXP_MAX && ma != 0) || (eb == EXP_MAX && mb != 0)
                 || (ea == 0 && eb == 0) || (ea == EXP_MAX && eb == EXP_MAX);
        inf_in  = (ea == EXP_MAX) || (eb == 0);
        zero_in = (ea == 0) || (eb == EXP_MAX);
        if (nan_in) begin
            return {sign, {EXP_WIDTH{1'b1}}, 1'b1, {(MANT_WIDTH - 1){1'b0}}};
        end
        if (inf_in) begin
            return {sign, {EXP_WIDTH{1'b1}}, {MANT_WIDTH{1'b0}}};
        end
        if (zero_in) begin
            return '0 | {sign, {(FP_WIDTH - 1){1'b0}}};
        end
        // Hidden bit and mantissa padded with MANT_WIDTH+2 zeros
        quo   = (((1 << MANT_WIDTH) + ma) << (MANT_WIDTH + 2)) / ((1 << MANT_WIDTH) + mb);
        exp_q = (ea - eb + EXP_BIAS) & EXP_MASK;
        if (quo >= (1 << (MANT_WIDTH + 2))) begin
            mant = (((quo >> 2) & MANT_MASK) + ((quo >> 1) & 1)) & MANT_MASK;
        end else begin
            exp_q = (exp_q - 1) & EXP_MASK;
            mant  = (((quo >> 1) & MANT_MASK) + (quo & 1)) & MANT_MASK;
        end
        // Overflow is only seen for a large exponent over a small one
        if (ea >= (1 << (EXP_WIDTH - 1)) && eb < (1 << (EXP_WIDTH - 1))
            && exp_q > EXP_MAX - 1) begin
            return {sign, {EXP_WIDTH{1'b1}}, {MANT_WIDTH{1'b0}}};
        end
        if (exp_q == 0 || exp_q > EXP_MAX) begin
            return {sign, {(FP_WIDTH - 1){1'b0}}};
        end
        return {sign, EXP_WIDTH'(exp_q), MANT_WIDTH'(mant)};
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [VEC_WIDTH-1:0] want,
                               input logic [VEC_WIDTH-1:0] got);
        check_count++;
        assert (got === want) else begin
            error_count++;
            $display("Mismatch %s %s: expected %0h, actual %0h", name, what, want, got);
        end
    endtask

    task automatic queue_expected(input string name, input logic [VEC_WIDTH-1:0] a,
                                  input logic [VEC_WIDTH-1:0] b);
        logic [VEC_WIDTH-1:0] expected;
        logic                 all_special;
        int                   lane;
        all_special = 1'b1;
        for (lane = 0; lane < NUM_LANES; lane++) begin
            expected[lane*FP_WIDTH +: FP_WIDTH] =
                ref_divide(a[lane*FP_WIDTH +: FP_WIDTH], b[lane*FP_WIDTH +: FP_WIDTH]);
            if (!special_pair(a[lane*FP_WIDTH +: FP_WIDTH], b[lane*FP_WIDTH +: FP_WIDTH])) begin
                all_special = 1'b0;
            end
        end
        expect_q.push_back(expected);
        start_q.push_back(cycle_count);
        latency_q.push_back(all_special ? LAT_SPECIAL : LAT_ORDINARY);
        name_q.push_back(name);
        accepted++;
    endtask

    task automatic wait_for_done();
        while (done_count < accepted) begin
            @(posedge CLK);
        end
    endtask

    task automatic send_vector(input string name, input logic [VEC_WIDTH-1:0] a,
                               input logic [VEC_WIDTH-1:0] b);
        @(posedge CLK);
        start <= 1'b1;
        a_vec <= a;
        b_vec <= b;
        queue_expected(name, a, b);
        @(posedge CLK);
        start <= 1'b0;
        wait_for_done();
    endtask

    // Sel 0 puts a special value in A, sel 1 in B, 2 and 3 leave both normal
    task automatic run_vectors(input string kind, input int count);
        logic [VEC_WIDTH-1:0] a;
        logic [VEC_WIDTH-1:0] b;
        logic [2*EXP_WIDTH-1:0] pair;
        int v;
        int lane;
        int idx;
        int sel;
        for (v = 0; v < count; v++) begin
            for (lane = 0; lane < NUM_LANES; lane++) begin
                idx = v * NUM_LANES + lane;
                a[lane*FP_WIDTH +: FP_WIDTH] = make_normal(NORM_EXP_LO, NORM_EXP_BITS);
                b[lane*FP_WIDTH +: FP_WIDTH] = make_normal(NORM_EXP_LO, NORM_EXP_BITS);
                if (kind == "special") begin
                    a[lane*FP_WIDTH +: FP_WIDTH] = make_special(idx / 4);
                    b[lane*FP_WIDTH +: FP_WIDTH] = make_special(idx % 4);
                end else if (kind == "mixed") begin
                    sel = int'(take_bits(2));
                    if (sel == 0) begin
                        a[lane*FP_WIDTH +: FP_WIDTH] = make_special(int'(take_bits(2)));
                    end else if (sel == 1) begin
                        b[lane*FP_WIDTH +: FP_WIDTH] = make_special(int'(take_bits(2)));
                    end
                end else if (kind == "range") begin
                    pair = range_pair(idx);
                    a[lane*FP_WIDTH +: FP_WIDTH] = make_normal(int'(pair[15:8]), 0);
                    b[lane*FP_WIDTH +: FP_WIDTH] = make_normal(int'(pair[7:0]), 0);
                end
            end
            send_vector($sformatf("%s %0d", kind, v), a, b);
        end
    endtask

    // The held start and a later one both land while busy and are dropped
    task automatic run_busy();
        logic [VEC_WIDTH-1:0] a[N_BUSY];
        logic [VEC_WIDTH-1:0] b[N_BUSY];
        int v;
        int lane;
        for (v = 0; v < N_BUSY; v++) begin
            for (lane = 0; lane < NUM_LANES; lane++) begin
                a[v][lane*FP_WIDTH +: FP_WIDTH] = make_normal(NORM_EXP_LO, NORM_EXP_BITS);
                b[v][lane*FP_WIDTH +: FP_WIDTH] = make_normal(NORM_EXP_LO, NORM_EXP_BITS);
            end
        end
        @(posedge CLK);
        start <= 1'b1;
        a_vec <= a[0];
        b_vec <= b[0];
        queue_expected("busy", a[0], b[0]);
        @(posedge CLK);
        a_vec <= a[1];
        b_vec <= b[1];
        @(posedge CLK);
        start <= 1'b0;
        repeat (3) @(posedge CLK);
        start <= 1'b1;
        a_vec <= a[2];
        b_vec <= b[2];
        @(posedge CLK);
        start <= 1'b0;
        wait_for_done();
        repeat (LAT_ORDINARY + 4) @(posedge CLK);
    endtask

    task automatic report_and_finish();
        error_count += i_vdiv_unit.i_vdiv_assertions.fail_count;
        $display("Checks: %0d, errors: %0d, accepted starts: %0d, done pulses: %0d",
                 check_count, error_count, accepted, done_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // Outputs are read at the edge, before that edge's updates land
    always @(posedge CLK) begin : compare_results
        logic [VEC_WIDTH-1:0] expected;
        string                name;
        int                   latency;
        int                   lane;
        if (nRST) begin
            if (done) begin
                done_count++;
                check_count++;
                assert (expect_q.size() != 0) else begin
                    error_count++;
                    $display("done pulsed with no accepted start in flight");
                end
                if (expect_q.size() != 0) begin
                    expected = expect_q.pop_front();
                    name     = name_q.pop_front();
                    latency  = cycle_count - start_q.pop_front() - 1;
                    check_value(name, "latency", latency_q.pop_front(), latency);
                    check_value(name, "busy at done", 0, busy);
                    for (lane = 0; lane < NUM_LANES; lane++) begin
                        check_value(name, $sformatf("lane %0d", lane),
                                    expected[lane*FP_WIDTH +: FP_WIDTH],
                                    result_vec[lane*FP_WIDTH +: FP_WIDTH]);
                    end
                end
            end else if (expect_q.size() == 0) begin
                check_count++;
                assert (!busy) else begin
                    error_count++;
                    $display("busy is high with no vector in flight");
                end
            end else if (cycle_count - start_q[0] >= 2) begin
                check_value(name_q[0], "busy in flight", 1, busy);
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge CLK);
        end
        error_count++;
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        report_and_finish();
    end

    initial begin : run_tests
        start = 1'b0;
        a_vec = '0;
        b_vec = '0;
        nRST  = 1'b1;
        // Falling edge ahead of the first clock clears the flops
        #1;
        nRST = 1'b0;
        repeat (4) @(posedge CLK);
        nRST <= 1'b1;
        @(posedge CLK);
        check_value("reset", "result_vec", '0, result_vec);
        check_value("reset", "busy", 0, busy);
        check_value("reset", "done", 0, done);
        run_vectors("random", N_RANDOM);
        run_vectors("special", N_SPECIAL);
        run_vectors("mixed", N_MIXED);
        run_vectors("range", N_RANGE);
        run_busy();
        repeat (LAT_ORDINARY + 4) @(posedge CLK);
        check_value("summary", "done pulses", accepted, done_count);
        report_and_finish();
    end

endmodule

//--- sim/vdiv_assertions.sv
// Vector divide protocol checks
`timescale 1ns/10ps

module vdiv_assertions (
    input logic CLK,
    input logic nRST,
    input logic start,
    input logic busy,
    input logic done
);
    // Set by an accepted start, cleared by the done that answers it
    logic armed;
    // Failed checks so far
    int   fail_count = 0;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            armed <= 1'b0;
        end else if (start && !busy) begin
            armed <= 1'b1;
        end else if (done) begin
            armed <= 1'b0;
        end
    end

    done_single_pulse: assert property (
        @(posedge CLK) disable iff (!nRST) done |=> !done
    ) else begin
        fail_count++;
        $error("done stayed high for more than one cycle");
    end

    done_after_start: assert property (
        @(posedge CLK) disable iff (!nRST) done |-> armed
    ) else begin
        fail_count++;
        $error("done pulsed without an accepted start");
    end

    // Status outputs stay quiet while reset is held
    quiet_in_reset: assert property (
        @(posedge CLK) !nRST |-> (!busy && !done)
    ) else begin
        fail_count++;
        $error("busy or done high during reset");
    end

endmodule

//--- rtl/vdiv_unit.sv
// Vector bfloat16 divide unit
`timescale 1ns/10ps

module vdiv_unit (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic                           start,
    input  logic [vdiv_pkg::VEC_WIDTH-1:0] a_vec,
    input  logic [vdiv_pkg::VEC_WIDTH-1:0] b_vec,
    output logic                           busy,
    output logic                           done,
    output logic [vdiv_pkg::VEC_WIDTH-1:0] result_vec
);
    import vdiv_pkg::*;

    logic                 lane_en;
    logic [NUM_LANES-1:0] lane_done;
    logic [VEC_WIDTH-1:0] lane_result;
    logic [VEC_WIDTH-1:0] op_a;
    logic [VEC_WIDTH-1:0] op_b;

    vdiv_collector i_collector (
        .CLK        (CLK),
        .nRST       (nRST),
        .start      (start),
        .a_vec      (a_vec),
        .b_vec      (b_vec),
        .lane_done  (lane_done),
        .lane_result(lane_result),
        .lane_en    (lane_en),
        .op_a       (op_a),
        .op_b       (op_b),
        .busy       (busy),
        .done       (done),
        .result_vec (result_vec)
    );

    // One divide lane per element, all started together
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        fp_div i_fp_div (
            .CLK   (CLK),
            .nRST  (nRST),
            .en    (lane_en),
            .a     (op_a[i*FP_WIDTH +: FP_WIDTH]),
            .b     (op_b[i*FP_WIDTH +: FP_WIDTH]),
            .result(lane_result[i*FP_WIDTH +: FP_WIDTH]),
            .done  (lane_done[i])
        );
    end

endmodule

//--- rtl/vdiv_collector.sv
// Vector start and result collection
`timescale 1ns/10ps

module vdiv_collector (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic                            start,
    input  logic [vdiv_pkg::VEC_WIDTH-1:0]  a_vec,
    input  logic [vdiv_pkg::VEC_WIDTH-1:0]  b_vec,
    input  logic [vdiv_pkg::NUM_LANES-1:0]  lane_done,
    input  logic [vdiv_pkg::VEC_WIDTH-1:0]  lane_result,
    output logic                            lane_en,
    output logic [vdiv_pkg::VEC_WIDTH-1:0]  op_a,
    output logic [vdiv_pkg::VEC_WIDTH-1:0]  op_b,
    output logic                            busy,
    output logic                            done,
    output logic [vdiv_pkg::VEC_WIDTH-1:0]  result_vec
);
    import vdiv_pkg::*;

    logic                 accept;
    logic [NUM_LANES-1:0] pending;
    logic [NUM_LANES-1:0] still_pending;
    logic [VEC_WIDTH-1:0] a_q;
    logic [VEC_WIDTH-1:0] b_q;

    // Starts while busy are dropped
    assign accept  = start && !busy;
    assign lane_en = accept;

    // Lanes see live operands in the accept cycle, the latched copy after that
    assign op_a = accept ? a_vec : a_q;
    assign op_b = accept ? b_vec : b_q;

    always_ff @(posedge CLK) begin
        if (accept) begin
            a_q <= a_vec;
            b_q <= b_vec;
        end
    end

    assign still_pending = pending & ~lane_done;

    // Busy until every lane has reported, then one done pulse
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            pending <= '0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                busy    <= 1'b1;
                pending <= '1;
            end else if (busy) begin
                pending <= still_pending;
                if (still_pending == '0) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Lane results are valid only during their done pulse
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            result_vec <= '0;
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (lane_done[i]) begin
                    result_vec[i*FP_WIDTH +: FP_WIDTH] <= lane_result[i*FP_WIDTH +: FP_WIDTH];
                end
            end
        end
    end

endmodule

//--- rtl/fp_div.sv
// Single lane bfloat16 divide
`timescale 1ns/10ps

module fp_div (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          en,
    input  logic [vdiv_pkg::FP_WIDTH-1:0] a,
    input  logic [vdiv_pkg::FP_WIDTH-1:0] b,
    output logic [vdiv_pkg::FP_WIDTH-1:0] result,
    output logic                          done
);
    import vdiv_pkg::*;

    logic                  sign_a;
    logic                  sign_b;
    logic                  sign_q;
    logic [EXP_WIDTH-1:0]  exp_a;
    logic [EXP_WIDTH-1:0]  exp_b;
    logic [MANT_WIDTH-1:0] mant_a;
    logic [MANT_WIDTH-1:0] mant_b;

    logic a_zero, b_zero;
    logic a_inf, b_inf;
    logic a_nan, b_nan;
    logic is_nan, is_inf, is_zero;
    logic skip_div;
    logic is_ovf, is_sub;

    logic                  div_en;
    logic                  div_done;
    logic [DIV_SIZE-1:0]   quotient;
    logic                  next_done;
    logic                  done_pulsed;

    logic [EXP_WIDTH:0]    exp_raw;
    logic [EXP_WIDTH:0]    exp_norm;
    logic [MANT_WIDTH-1:0] mant_q;

    assign {sign_a, exp_a, mant_a} = a;
    assign {sign_b, exp_b, mant_b} = b;
    assign sign_q = sign_a ^ sign_b;

    // Operand classes, subnormals are taken as zero
    assign a_zero = (exp_a == '0);
    assign b_zero = (exp_b == '0);
    assign a_inf  = (&exp_a) && (mant_a == '0);
    assign b_inf  = (&exp_b) && (mant_b == '0);
    assign a_nan  = (&exp_a) && (mant_a != '0);
    assign b_nan  = (&exp_b) && (mant_b != '0);

    // Special results, 0/0 and inf/inf give NaN
    assign is_nan   = a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf);
    assign is_inf   = !is_nan && (a_inf || b_zero);
    assign is_zero  = !is_nan && !is_inf && (a_zero || b_inf);
    assign skip_div = is_nan || is_inf || is_zero;

    // Done is a single pulse from either the special path or the divider
    assign next_done = (en && skip_div) || div_done;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            done        <= 1'b0;
            done_pulsed <= 1'b0;
        end else begin
            done        <= next_done && !done_pulsed;
            done_pulsed <= done_pulsed ? 1'b0 : next_done;
        end
    end

    // Mantissa divide with hidden bits, dividend padded for extra quotient bits
    assign div_en = en && !skip_div;

    int_divider #(
        .SIZE(DIV_SIZE),
        .SKIP(DIV_SKIP)
    ) i_int_divider (
        .CLK   (CLK),
        .nRST  (nRST),
        .en    (div_en),
        .x     ({!a_zero, mant_a, {(MANT_WIDTH + 2){1'b0}}}),
        .y     ({{(MANT_WIDTH + 2){1'b0}}, !b_zero, mant_b}),
        .result(quotient),
        .done  (div_done)
    );

    // Biased exponent, one extra bit catches wrap below zero
    assign exp_raw = {1'b0, exp_a} - {1'b0, exp_b} + (EXP_WIDTH + 1)'(EXP_BIAS);

    // Normalize on the quotient MSB and round by adding the first dropped bit
    always_comb begin
        if (exp_raw == '0) begin
            mant_q   = quotient[MANT_WIDTH+2:3] + quotient[2];
            exp_norm = exp_raw;
        end else if (exp_raw == (EXP_WIDTH + 1)'(1)) begin
            // Only survives when the quotient is already in [1,2)
            mant_q   = quotient[MANT_WIDTH+1:2] + quotient[1];
            exp_norm = {{EXP_WIDTH{1'b0}}, quotient[MANT_WIDTH+2]};
        end else if (quotient[MANT_WIDTH+2]) begin
            mant_q   = quotient[MANT_WIDTH+1:2] + quotient[1];
            exp_norm = exp_raw;
        end else begin
            mant_q   = quotient[MANT_WIDTH:1] + quotient[0];
            exp_norm = exp_raw - 1'b1;
        end
    end

    // Overflow only when a large exponent is divided by a small one
    assign is_ovf = !skip_div && exp_a[EXP_WIDTH-1] && !exp_b[EXP_WIDTH-1]
                    && (exp_norm > (EXP_WIDTH + 1)'((1 << EXP_WIDTH) - 2));
    assign is_sub = exp_norm[EXP_WIDTH] || (exp_norm == '0);

    // NaN first, then infinity, then flush to zero
    always_comb begin
        if (is_nan) begin
            result = {sign_q, {EXP_WIDTH{1'b1}}, 1'b1, {(MANT_WIDTH - 1){1'b0}}};
        end else if (is_inf || is_ovf) begin
            result = {sign_q, {EXP_WIDTH{1'b1}}, {MANT_WIDTH{1'b0}}};
        end else if (is_zero || is_sub) begin
            result = {sign_q, {EXP_WIDTH{1'b0}}, {MANT_WIDTH{1'b0}}};
        end else begin
            result = {sign_q, exp_norm[EXP_WIDTH-1:0], mant_q};
        end
    end

endmodule

//--- rtl/int_divider.sv
// Restoring integer divider
`timescale 1ns/10ps

module int_divider #(
    parameter int SIZE = vdiv_pkg::DIV_SIZE,
    parameter int SKIP = vdiv_pkg::DIV_SKIP
) (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            en,
    input  logic [SIZE-1:0] x,
    input  logic [SIZE-1:0] y,
    output logic [SIZE-1:0] result,
    output logic            done
);
    localparam int CYCLES = SIZE - SKIP;
    localparam int CNT_W  = $clog2(CYCLES + 1);

    logic [SIZE-1:0]   rem;
    logic [CYCLES:0]   dvd;
    logic [CYCLES-1:0] quo;
    logic [CNT_W-1:0]  count;

    logic [SIZE-1:0]   src_rem;
    logic [CYCLES:0]   src_dvd;
    logic [CYCLES-1:0] src_quo;
    logic [SIZE:0]     shifted;
    logic [SIZE:0]     diff;
    logic              ge;
    logic [SIZE-1:0]   rem_next;

    // The top SKIP-1 dividend bits are smaller than any normalized divisor,
    // so they go straight into the partial remainder and the first real
    // step happens in the load cycle
    assign src_rem = en ? (x >> (CYCLES + 1)) : rem;
    assign src_dvd = en ? x[CYCLES:0] : dvd;
    assign src_quo = en ? '0 : quo;

    // One restoring step: shift in the next dividend bit, subtract if it fits
    assign shifted  = {src_rem, src_dvd[CYCLES]};
    assign diff     = shifted - {1'b0, y};
    assign ge       = (shifted >= {1'b0, y});
    assign rem_next = ge ? diff[SIZE-1:0] : shifted[SIZE-1:0];

    always_ff @(posedge CLK) begin
        if (en || (count != '0)) begin
            rem <= rem_next;
            dvd <= {src_dvd[CYCLES-1:0], 1'b0};
            quo <= {src_quo[CYCLES-2:0], ge};
        end
    end

    // Step counter, done rises CYCLES clocks after en is raised
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
            done  <= 1'b0;
        end else if (en) begin
            count <= CNT_W'(CYCLES - 1);
            done  <= 1'b0;
        end else if (count != '0) begin
            count <= count - 1'b1;
            done  <= (count == CNT_W'(1));
        end else begin
            done <= 1'b0;
        end
    end

    // Last quotient bit comes from the step logic on the held remainder
    assign result = {{(SKIP - 1){1'b0}}, quo, ge};

endmodule

//--- rtl/vdiv_pkg.sv
// Vector divide definitions

package vdiv_pkg;

    // bfloat16 element format
    localparam int EXP_WIDTH  = 8;
    localparam int MANT_WIDTH = 7;
    localparam int FP_WIDTH   = 1 + EXP_WIDTH + MANT_WIDTH;
    localparam int EXP_BIAS   = (1 << (EXP_WIDTH - 1)) - 1;

    // Lanes per vector and packed vector width
    localparam int NUM_LANES = 4;
    localparam int VEC_WIDTH = NUM_LANES * FP_WIDTH;

    // Integer divider sizing
    // Dividend is hidden bit, mantissa and MANT_WIDTH+2 zero bits
    localparam int DIV_SIZE   = 2 * MANT_WIDTH + 3;
    // Leading quotient bits that need no divider step
    localparam int DIV_SKIP   = MANT_WIDTH + 1;
    localparam int DIV_CYCLES = DIV_SIZE - DIV_SKIP;

endpackage
